//--- src/tlp_pkg.sv
// Shared widths, typedefs and stream structs for the 64/128-bit TLP converters
// Core beats carry one or two dwords; byte keep is either 8'h0f or 8'hff

package tlp_pkg;

    // --------------------------------------------------
    // Stream widths
    // --------------------------------------------------
    localparam int DW_W        = 32;
    localparam int BEAT_W      = 64;
    localparam int WORD_W      = 128;
    localparam int BYTE_KEEP_W = 8;
    localparam int DW_KEEP_W   = 4;
    localparam int BAR_HIT_W   = 7;
    localparam int DW_COUNT_W  = 3;

    // Default counter bit for the link LED blink
    localparam int BLINK_BIT_DEFAULT = 25;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    typedef logic [DW_W-1:0]        dw_t;
    typedef logic [BEAT_W-1:0]      beat64_data_t;
    typedef logic [WORD_W-1:0]      word128_data_t;
    typedef logic [BYTE_KEEP_W-1:0] byte_keep_t;
    typedef logic [DW_KEEP_W-1:0]   dw_keep_t;
    typedef logic [BAR_HIT_W-1:0]   bar_hit_t;

    // Dwords held in the packer, 0 to 4
    typedef logic [DW_COUNT_W-1:0]  dw_count_t;

    // Legal byte keep values of a core beat
    localparam byte_keep_t KEEP_LOW_DW  = 8'h0f;
    localparam byte_keep_t KEEP_BOTH_DW = 8'hff;

    // --------------------------------------------------
    // Stream structs
    // --------------------------------------------------

    // Core side beat, valid and ready travel separately
    typedef struct packed {
        beat64_data_t data;
        byte_keep_t   keep;
        logic         last;
        bar_hit_t     bar_hit;
    } core_beat_t;

    // Bit order gives first at bit 0, last at bit 1, bar_hit at [8:2]
    typedef struct packed {
        bar_hit_t bar_hit;
        logic     last;
        logic     first;
    } tlps_user_t;

    typedef struct packed {
        word128_data_t tdata;
        dw_keep_t      tkeepdw;
        logic          tlast;
        tlps_user_t    tuser;
    } tlps_word_t;

    // Splitter phase
    typedef enum logic [0:0] {
        LOW_HALF  = 1'b0,
        HIGH_HALF = 1'b1
    } split_state_t;

endpackage

//--- src/tlp_rx_packer.sv
// Packs 64-bit core receive beats into 128-bit TLP stream words
// The core receive port is never stalled, so there is no ready on either side
// Output word is valid for one cycle and must be taken by the sink

`timescale 1ns/1ns

module tlp_rx_packer import tlp_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    input  core_beat_t core_rx,
    input  logic       core_rx_valid,
    output tlps_word_t tlps_rx,
    output logic       tlps_rx_valid
);

    word128_data_t acc_data;
    dw_count_t     dw_count;
    logic          first_q;
    logic          last_q;
    bar_hit_t      bar_hit_q;

    logic          emit;
    dw_count_t     wr_base;
    dw_count_t     beat_dws;
    dw_keep_t      keep_dw;

    // --------------------------------------------------
    // Fill tracking
    // --------------------------------------------------

    // Word goes out once three dwords are held or the TLP has ended
    assign emit = last_q || (dw_count > 3'd2);

    // New beat restarts at dword 0 when the held word leaves this cycle
    assign wr_base = emit ? 3'd0 : dw_count;

    // Upper dword present when byte 4 is kept
    assign beat_dws = core_rx.keep[4] ? 3'd2 : 3'd1;

    // Contiguous dword keep from bit 0
    assign keep_dw = {(dw_count > 3'd3), (dw_count > 3'd2), (dw_count > 3'd1), 1'b1};

    // --------------------------------------------------
    // Accumulator
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (core_rx_valid) begin
            case (wr_base)
                3'd0:    acc_data[63:0]   <= core_rx.data;
                3'd1:    acc_data[95:32]  <= core_rx.data;
                default: acc_data[127:64] <= core_rx.data;
            endcase
        end
    end

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            dw_count  <= '0;
            first_q   <= 1'b1;
            last_q    <= 1'b0;
            bar_hit_q <= '0;
        end else if (core_rx_valid) begin
            dw_count  <= wr_base + beat_dws;
            // Next word opens a TLP only if the emitted one closed it
            first_q   <= emit ? last_q : first_q;
            last_q    <= core_rx.last;
            bar_hit_q <= core_rx.bar_hit;
        end else if (emit) begin
            dw_count  <= '0;
            first_q   <= last_q;
            last_q    <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Output word
    // --------------------------------------------------
    always_comb begin
        tlps_rx.tdata         = acc_data;
        tlps_rx.tkeepdw       = keep_dw;
        tlps_rx.tlast         = last_q;
        tlps_rx.tuser.first   = first_q;
        tlps_rx.tuser.last    = last_q;
        tlps_rx.tuser.bar_hit = bar_hit_q;
    end

    assign tlps_rx_valid = emit;

endmodule

//--- src/tlp_tx_splitter.sv
// Splits 128-bit TLP stream words into 64-bit core transmit beats
// Source must hold the word and valid stable until tlps_tx_ready
// The low beat is passed through combinationally, no word buffer

`timescale 1ns/1ns

module tlp_tx_splitter import tlp_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    input  tlps_word_t tlps_tx,
    input  logic       tlps_tx_valid,
    input  logic       core_tx_ready,
    output logic       tlps_tx_ready,
    output core_beat_t core_tx,
    output logic       core_tx_valid
);

    split_state_t state;
    split_state_t state_next;

    logic         has_high;
    logic         final_beat;
    logic         beat_taken;

    // Dword 2 present means a second core beat
    assign has_high = tlps_tx.tkeepdw[2];

    assign final_beat = (state == HIGH_HALF) || !has_high;

    assign core_tx_valid = tlps_tx_valid;
    assign beat_taken    = core_tx_valid && core_tx_ready;

    // Word is released only with its last beat
    assign tlps_tx_ready = core_tx_ready && final_beat;

    // --------------------------------------------------
    // Beat formation
    // --------------------------------------------------
    always_comb begin
        core_tx.bar_hit = '0;
        if (state == HIGH_HALF) begin
            core_tx.data = tlps_tx.tdata[127:64];
            core_tx.keep = tlps_tx.tkeepdw[3] ? KEEP_BOTH_DW : KEEP_LOW_DW;
            core_tx.last = tlps_tx.tlast;
        end else begin
            core_tx.data = tlps_tx.tdata[63:0];
            core_tx.keep = tlps_tx.tkeepdw[1] ? KEEP_BOTH_DW : KEEP_LOW_DW;
            // Last only when no high beat follows
            core_tx.last = tlps_tx.tlast && !has_high;
        end
    end

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            LOW_HALF: begin
                if (beat_taken && has_high) begin
                    state_next = HIGH_HALF;
                end
            end
            HIGH_HALF: begin
                if (beat_taken) begin
                    state_next = LOW_HALF;
                end
            end
            default: begin
                state_next = LOW_HALF;
            end
        endcase
    end

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            state <= LOW_HALF;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- src/link_led.sv
// Link LED, lit while the link is up, blinking from a free counter when down
// Blink period is 2^(LED_BLINK_BIT+1) cycles of clk_pcie

`timescale 1ns/1ns

module link_led import tlp_pkg::*; #(
    parameter int LED_BLINK_BIT = BLINK_BIT_DEFAULT
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    output logic led_state
);

    // Only bits up to the blink bit are needed
    logic [LED_BLINK_BIT:0] blink_cnt;

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    assign led_state = link_up || blink_cnt[LED_BLINK_BIT];

endmodule

//--- src/pcie_tlp_bridge.sv
// Top level of the PCIe TLP stream width converters and the link LED
// Single clock domain on clk_pcie; receive path has no back-pressure
// Transmit beats always carry a zero bar_hit

`timescale 1ns/1ns

module pcie_tlp_bridge import tlp_pkg::*; #(
    parameter int LED_BLINK_BIT = BLINK_BIT_DEFAULT
) (
    input  logic       clk_pcie,
    input  logic       rst,

    // Core receive beats
    input  core_beat_t core_rx,
    input  logic       core_rx_valid,

    // Receive TLP stream
    output tlps_word_t tlps_rx,
    output logic       tlps_rx_valid,

    // Transmit TLP stream
    input  tlps_word_t tlps_tx,
    input  logic       tlps_tx_valid,
    output logic       tlps_tx_ready,

    // Core transmit beats
    output core_beat_t core_tx,
    output logic       core_tx_valid,
    input  logic       core_tx_ready,

    // Status
    input  logic       link_up,
    output logic       led_state
);

    // --------------------------------------------------
    // Receive, 64 to 128 bit
    // --------------------------------------------------
    tlp_rx_packer u_rx_packer (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .core_rx       (core_rx),
        .core_rx_valid (core_rx_valid),
        .tlps_rx       (tlps_rx),
        .tlps_rx_valid (tlps_rx_valid)
    );

    // --------------------------------------------------
    // Transmit, 128 to 64 bit
    // --------------------------------------------------
    tlp_tx_splitter u_tx_splitter (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .tlps_tx       (tlps_tx),
        .tlps_tx_valid (tlps_tx_valid),
        .core_tx_ready (core_tx_ready),
        .tlps_tx_ready (tlps_tx_ready),
        .core_tx       (core_tx),
        .core_tx_valid (core_tx_valid)
    );

    // Link status LED
    link_led #(
        .LED_BLINK_BIT (LED_BLINK_BIT)
    ) u_link_led (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .link_up   (link_up),
        .led_state (led_state)
    );

endmodule

//--- test/tb_pcie_tlp_bridge_asserts.sv
// Stream rule checks bound into pcie_tlp_bridge
// Assumes receive beats are full except the final beat of each TLP

`timescale 1ns/1ns

module tb_pcie_tlp_bridge_asserts import tlp_pkg::*; (
    input logic       clk_pcie,
    input logic       rst,
    input core_beat_t core_rx,
    input logic       core_rx_valid,
    input tlps_word_t tlps_rx,
    input logic       tlps_rx_valid,
    input core_beat_t core_tx,
    input logic       core_tx_valid,
    input logic       core_tx_ready,
    input logic       link_up,
    input logic       led_state
);

    // Failure count, read by the testbench
    int violations = 0;

    logic [2:0] fill;
    logic       word_due;
    logic       expect_first;
    logic [2:0] base;
    logic [2:0] fill_next;
    bar_hit_t   last_bar;

    // --------------------------------------------------
    // Reference fill model of the packer
    // --------------------------------------------------
    assign base      = word_due ? 3'd0 : fill;
    assign fill_next = base + ((core_rx.keep == 8'hff) ? 3'd2 : 3'd1);

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            fill         <= '0;
            word_due     <= 1'b0;
            expect_first <= 1'b1;
            last_bar     <= '0;
        end else begin
            if (core_rx_valid) begin
                fill     <= fill_next;
                word_due <= core_rx.last || (fill_next >= 3'd3);
                last_bar <= core_rx.bar_hit;
            end else begin
                fill     <= base;
                word_due <= 1'b0;
            end
            // Word after a TLP end opens the next TLP
            if (tlps_rx_valid) begin
                expect_first <= tlps_rx.tlast;
            end
        end
    end

    // --------------------------------------------------
    // Properties
    // --------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk_pcie)
        $fell(rst) |-> !tlps_rx_valid && !core_tx_valid)
        else begin
            $error("stream valid high in the first cycle after reset");
            violations++;
        end

    a_rx_latency: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid == word_due)
        else begin
            $error("tlps_rx_valid not one cycle after the completing beat");
            violations++;
        end

    a_rx_keep: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid |-> tlps_rx.tkeepdw inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}
                          && $countones(tlps_rx.tkeepdw) == int'(fill))
        else begin
            $error("tlps_rx dword keep wrong or not contiguous from bit 0");
            violations++;
        end

    a_rx_flags: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid |-> tlps_rx.tuser.first == expect_first
                          && tlps_rx.tuser.last == tlps_rx.tlast)
        else begin
            $error("tlps_rx first or last flag wrong");
            violations++;
        end

    a_rx_bar: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid |-> tlps_rx.tuser.bar_hit == last_bar)
        else begin
            $error("tlps_rx bar_hit not taken from the latest receive beat");
            violations++;
        end

    a_tx_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx_valid && !core_tx_ready |=> core_tx_valid && $stable(core_tx))
        else begin
            $error("core_tx changed while stalled");
            violations++;
        end

    a_tx_keep: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx_valid |-> core_tx.keep inside {8'h0f, 8'hff} && core_tx.bar_hit == '0)
        else begin
            $error("core_tx keep illegal or bar_hit not zero");
            violations++;
        end

    a_led_up: assert property (@(posedge clk_pcie) disable iff (rst)
        link_up |-> led_state)
        else begin
            $error("led_state low while link is up");
            violations++;
        end

endmodule

bind pcie_tlp_bridge tb_pcie_tlp_bridge_asserts u_asserts (
    .clk_pcie      (clk_pcie),
    .rst           (rst),
    .core_rx       (core_rx),
    .core_rx_valid (core_rx_valid),
    .tlps_rx       (tlps_rx),
    .tlps_rx_valid (tlps_rx_valid),
    .core_tx       (core_tx),
    .core_tx_valid (core_tx_valid),
    .core_tx_ready (core_tx_ready),
    .link_up       (link_up),
    .led_state     (led_state)
);

//--- test/tb_pcie_tlp_bridge.sv
// Loopback testbench, every tlps_rx word is sent back on tlps_tx
// Inputs change on the falling edge; handshakes are sampled on the rising edge
// LED_BLINK_BIT is 3, so the LED toggles every 8 cycles while the link is down

`timescale 1ns/1ns

module tb_pcie_tlp_bridge import tlp_pkg::*; ();

    localparam int BLINK_BIT      = 3;
    localparam int N_CLEAN        = 10;
    localparam int N_STALL        = 30;
    localparam int N_TLPS         = N_CLEAN + N_STALL;
    localparam int TIMEOUT_CYCLES = N_TLPS * 40 + 200;

    logic       clk_pcie = 1'b0;
    logic       rst;
    core_beat_t core_rx;
    logic       core_rx_valid;
    tlps_word_t tlps_rx;
    logic       tlps_rx_valid;
    tlps_word_t tlps_tx;
    logic       tlps_tx_valid;
    logic       tlps_tx_ready;
    core_beat_t core_tx;
    logic       core_tx_valid;
    logic       core_tx_ready;
    logic       link_up;
    logic       led_state;

    int         seed = 85803;
    int         cycles = 0;
    int         errors = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    string      test_name = "reset";
    bit         stalls_on = 1'b0;
    bit         stall_pat [0:TIMEOUT_CYCLES];

    // Loopback words and the dwords still owed on core_tx
    tlps_word_t loop_q [$];
    dw_t        exp_dw [$];
    bit         exp_end [$];

    pcie_tlp_bridge #(
        .LED_BLINK_BIT (BLINK_BIT)
    ) dut0 (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .core_rx       (core_rx),
        .core_rx_valid (core_rx_valid),
        .tlps_rx       (tlps_rx),
        .tlps_rx_valid (tlps_rx_valid),
        .tlps_tx       (tlps_tx),
        .tlps_tx_valid (tlps_tx_valid),
        .tlps_tx_ready (tlps_tx_ready),
        .core_tx       (core_tx),
        .core_tx_valid (core_tx_valid),
        .core_tx_ready (core_tx_ready),
        .link_up       (link_up),
        .led_state     (led_state)
    );

    always #4 clk_pcie = ~clk_pcie;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic int total_errors();
        return errors + dut0.u_asserts.violations;
    endfunction

    task automatic report_test(input int start);
        int errs;
        errs = total_errors() - start;
        if (errs == 0) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s: %0d errors", test_name, errs);
        end
    endtask

    // Compare one accepted core_tx beat with the dwords sent on core_rx
    task automatic check_beat(input core_beat_t beat);
        int  n;
        int  k;
        dw_t got;
        dw_t want;
        bit  got_end;
        bit  want_end;
        n = (beat.keep == 8'hff) ? 2 : 1;
        for (k = 0; k < n; k++) begin
            got     = beat.data[k*32 +: 32];
            got_end = beat.last && (k == n - 1);
            if (exp_dw.size() == 0) begin
                $display("Error in %s: core_tx sent a dword that was never received", test_name);
                errors++;
            end else begin
                want     = exp_dw.pop_front();
                want_end = exp_end.pop_front();
                if (got != want) begin
                    $display("ERROR %s: dword expected %h actual %h", test_name, want, got);
                    errors++;
                end
                if (got_end != want_end) begin
                    $display("ERROR %s: TLP end expected %0d actual %0d",
                             test_name, want_end, got_end);
                    errors++;
                end
            end
        end
    endtask

    // One TLP of len_dw dwords as full beats plus an optional half beat
    task automatic send_tlp(input int len_dw, input bit gaps);
        int         left;
        int         r;
        core_beat_t beat;
        r            = $random(seed);
        beat.bar_hit = r[6:0];
        left         = len_dw;
        while (left > 0) begin
            beat.data[31:0]  = $random(seed);
            beat.data[63:32] = $random(seed);
            beat.keep        = (left > 1) ? 8'hff : 8'h0f;
            beat.last        = (left <= 2);
            exp_dw.push_back(beat.data[31:0]);
            exp_end.push_back(left == 1);
            if (left > 1) begin
                exp_dw.push_back(beat.data[63:32]);
                exp_end.push_back(left == 2);
            end
            core_rx       = beat;
            core_rx_valid = 1'b1;
            @(negedge clk_pcie);
            left = (left > 1) ? left - 2 : 0;
            r = $random(seed);
            if (gaps && r[1:0] == 2'b00) begin
                core_rx_valid = 1'b0;
                @(negedge clk_pcie);
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_dw.size() != 0 || loop_q.size() != 0) begin
            @(negedge clk_pcie);
        end
    endtask

    // LED must toggle every 2^BLINK_BIT cycles with the link down
    task automatic check_blink();
        int   since;
        int   toggles;
        logic prev;
        link_up = 1'b1;
        repeat (16) begin
            @(negedge clk_pcie);
            if (led_state !== 1'b1) begin
                $display("ERROR %s: led_state expected 1 actual %b", test_name, led_state);
                errors++;
            end
        end
        link_up = 1'b0;
        @(negedge clk_pcie);
        prev    = led_state;
        since   = -1;
        toggles = 0;
        repeat (64) begin
            @(negedge clk_pcie);
            if (since >= 0) begin
                since++;
            end
            if (led_state != prev) begin
                if (since >= 0 && since != (1 << BLINK_BIT)) begin
                    $display("ERROR %s: toggle interval expected %0d actual %0d",
                             test_name, 1 << BLINK_BIT, since);
                    errors++;
                end
                toggles++;
                since = 0;
                prev  = led_state;
            end
        end
        if (toggles != 64 / (1 << BLINK_BIT)) begin
            $display("ERROR %s: toggles expected %0d actual %0d",
                     test_name, 64 / (1 << BLINK_BIT), toggles);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Rising edge monitor and cycle limit
    // --------------------------------------------------
    always @(posedge clk_pcie) begin
        if (!rst) begin
            if (tlps_tx_valid && tlps_tx_ready) begin
                loop_q.delete(0);
            end
            if (tlps_rx_valid) begin
                loop_q.push_back(tlps_rx);
            end
            if (core_tx_valid && core_tx_ready) begin
                check_beat(core_tx);
            end
        end
    end

    always @(posedge clk_pcie) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Transmit side, queue head on tlps_tx and random core stalls
    initial begin
        tlps_tx       = '0;
        tlps_tx_valid = 1'b0;
        core_tx_ready = 1'b0;
        forever begin
            @(negedge clk_pcie);
            core_tx_ready = !(stalls_on && stall_pat[cycles]);
            if (loop_q.size() > 0) begin
                tlps_tx       = loop_q[0];
                tlps_tx_valid = 1'b1;
            end else begin
                tlps_tx_valid = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int i;
        int r;
        int start;
        rst           = 1'b1;
        core_rx       = '0;
        core_rx_valid = 1'b0;
        link_up       = 1'b0;
        for (i = 0; i <= TIMEOUT_CYCLES; i++) begin
            r            = $random(seed);
            stall_pat[i] = (r[1:0] == 2'b00);
        end
        repeat (2) @(negedge clk_pcie);
        rst   = 1'b0;
        start = total_errors();
        @(negedge clk_pcie);
        report_test(start);

        test_name = "round_trip";
        link_up   = 1'b1;
        start     = total_errors();
        for (i = 0; i < N_CLEAN; i++) begin
            send_tlp(1 + (($random(seed) & 32'hffff) % 9), 1'b0);
        end
        core_rx_valid = 1'b0;
        wait_drain();
        report_test(start);

        @(posedge clk_pcie);
        stalls_on = 1'b1;
        @(negedge clk_pcie);
        test_name = "back_pressure";
        start     = total_errors();
        for (i = 0; i < N_STALL; i++) begin
            send_tlp(1 + (($random(seed) & 32'hffff) % 9), 1'b1);
        end
        core_rx_valid = 1'b0;
        wait_drain();
        report_test(start);

        test_name = "led";
        start     = total_errors();
        check_blink();
        report_test(start);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && total_errors() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/tlp_pkg.sv
src/tlp_rx_packer.sv
src/tlp_tx_splitter.sv
src/link_led.sv
src/pcie_tlp_bridge.sv
test/tb_pcie_tlp_bridge_asserts.sv
test/tb_pcie_tlp_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the testbench with Verilator from build.f, runs it and checks the log.
# The exit status is nonzero when the pass line is missing from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
    --top-module tb_pcie_tlp_bridge \
    -f build.f \
    && ./obj_dir/Vtb_pcie_tlp_bridge +verilator+error+limit+1000 2>&1 | tee "$LOG" \
    && grep -qx "TESTS PASSED" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }
